//--- core_mem.f
hdl/core_mem_pkg.sv
hdl/core_mem_icache.sv
hdl/core_mem_lsu.sv
hdl/core_mem_arbiter.sv
hdl/core_mem_sram.sv
hdl/core_mem_top.sv
bench/core_mem_clkgen.sv
bench/core_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core_mem testbench with Verilator, result taken from the log

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module core_mem_tb \
    -f core_mem.f -o core_mem_sim \
    && ./obj_dir/core_mem_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "Some tests failed" "$LOG" && exit 1
grep -q "All tests passed" "$LOG" || exit 1
exit 0

//--- bench/core_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_tb;

    localparam int MEM_WORDS    = 512;
    localparam int ICACHE_LINES = 16;
    localparam int RESET_CYCLES = 8;
    localparam int STEP_CYCLES  = 40;

    localparam logic [1:0] P_DATA  = 2'd0;
    localparam logic [1:0] P_FETCH = 2'd1;
    localparam logic [1:0] P_BOTH  = 2'd2;

    localparam core_mem_pkg::ls_size_e SZ_B = core_mem_pkg::LS_BYTE;
    localparam core_mem_pkg::ls_size_e SZ_H = core_mem_pkg::LS_HALF;
    localparam core_mem_pkg::ls_size_e SZ_W = core_mem_pkg::LS_WORD;
    localparam core_mem_pkg::ls_size_e SZ_D = core_mem_pkg::LS_DOUBLE;

    // fetch fields are only used by fetch and paired rows
    typedef struct packed {
        logic [1:0]             port;
        logic [31:0]            addr;
        logic                   we;
        core_mem_pkg::ls_size_e size;
        logic                   uns;
        logic [63:0]            wdata;
        logic [63:0]            exp_data;
        logic                   exp_err;
        logic [31:0]            pc;
        logic [31:0]            exp_inst;
    } step_t;

    logic                     clk;
    logic                     rst_n_i;
    logic                     fetch_valid_i;
    logic [31:0]              fetch_pc_i;
    logic                     fetch_rsp_ready_i;
    logic                     lsu_valid_i;
    core_mem_pkg::lsu_req_t   lsu_req_i;
    logic                     lsu_rsp_ready_i;
    logic                     fetch_ready_o;
    logic                     fetch_rsp_valid_o;
    core_mem_pkg::fetch_rsp_t fetch_rsp_o;
    logic                     lsu_ready_o;
    logic                     lsu_rsp_valid_o;
    core_mem_pkg::lsu_rsp_t   lsu_rsp_o;

    step_t steps[$];
    int    seed = 32'h69f5;
    int    fails = 0;
    int    step_fails;
    int    hold_d;
    int    hold_f;
    logic  table_ready = 1'b0;

    core_mem_clkgen #(.PERIOD_NS(10)) u_clkgen (.clk_o(clk));

    core_mem_top #(
        .MEM_WORDS    (MEM_WORDS),
        .ICACHE_LINES (ICACHE_LINES)
    ) UUT (
        .*
    );

    // **************************************************************************
    // table rows
    // **************************************************************************
    task automatic load_step(input logic [31:0] a, input core_mem_pkg::ls_size_e sz,
                             input logic u, input logic [63:0] d, input logic e);
        steps.push_back('{P_DATA, a, 1'b0, sz, u, 64'h0, d, e, 32'h0, 32'h0});
    endtask

    task automatic store_step(input logic [31:0] a, input core_mem_pkg::ls_size_e sz,
                              input logic [63:0] w, input logic e);
        steps.push_back('{P_DATA, a, 1'b1, sz, 1'b0, w, 64'h0, e, 32'h0, 32'h0});
    endtask

    task automatic fetch_step(input logic [31:0] pc, input logic [31:0] inst, input logic e);
        steps.push_back('{P_FETCH, 32'h0, 1'b0, SZ_D, 1'b0, 64'h0, 64'h0, e, pc, inst});
    endtask

    // load and fetch issued on the same edge
    task automatic paired_step(input logic [31:0] a, input core_mem_pkg::ls_size_e sz,
                               input logic u, input logic [63:0] d,
                               input logic [31:0] pc, input logic [31:0] inst);
        steps.push_back('{P_BOTH, a, 1'b0, sz, u, 64'h0, d, 1'b0, pc, inst});
    endtask

    task automatic fill_table();
        // doubles read back unchanged
        store_step(32'h8000_0000, SZ_D, 64'h0123_4567_89ab_cdef, 1'b0);
        store_step(32'h8000_0008, SZ_D, 64'hfedc_ba98_7654_3210, 1'b0);
        store_step(32'h8000_0ff8, SZ_D, 64'ha5a5_5a5a_c3c3_3c3c, 1'b0);
        load_step(32'h8000_0000, SZ_D, 1'b0, 64'h0123_4567_89ab_cdef, 1'b0);
        load_step(32'h8000_0008, SZ_D, 1'b0, 64'hfedc_ba98_7654_3210, 1'b0);
        load_step(32'h8000_0ff8, SZ_D, 1'b0, 64'ha5a5_5a5a_c3c3_3c3c, 1'b0);
        // bytes f1 80 00 ff 02 7f 81 80 from offset 0 up
        store_step(32'h8000_0010, SZ_D, 64'h8081_7f02_ff00_80f1, 1'b0);
        load_step(32'h8000_0010, SZ_B, 1'b0, 64'hffff_ffff_ffff_fff1, 1'b0);
        load_step(32'h8000_0011, SZ_B, 1'b0, 64'hffff_ffff_ffff_ff80, 1'b0);
        load_step(32'h8000_0011, SZ_B, 1'b1, 64'h0000_0000_0000_0080, 1'b0);
        load_step(32'h8000_0012, SZ_B, 1'b0, 64'h0000_0000_0000_0000, 1'b0);
        load_step(32'h8000_0013, SZ_B, 1'b0, 64'hffff_ffff_ffff_ffff, 1'b0);
        load_step(32'h8000_0014, SZ_B, 1'b1, 64'h0000_0000_0000_0002, 1'b0);
        load_step(32'h8000_0015, SZ_B, 1'b0, 64'h0000_0000_0000_007f, 1'b0);
        load_step(32'h8000_0016, SZ_B, 1'b0, 64'hffff_ffff_ffff_ff81, 1'b0);
        load_step(32'h8000_0017, SZ_B, 1'b1, 64'h0000_0000_0000_0080, 1'b0);
        load_step(32'h8000_0010, SZ_H, 1'b0, 64'hffff_ffff_ffff_80f1, 1'b0);
        load_step(32'h8000_0012, SZ_H, 1'b1, 64'h0000_0000_0000_ff00, 1'b0);
        load_step(32'h8000_0014, SZ_H, 1'b0, 64'h0000_0000_0000_7f02, 1'b0);
        load_step(32'h8000_0016, SZ_H, 1'b0, 64'hffff_ffff_ffff_8081, 1'b0);
        load_step(32'h8000_0016, SZ_H, 1'b1, 64'h0000_0000_0000_8081, 1'b0);
        load_step(32'h8000_0010, SZ_W, 1'b0, 64'hffff_ffff_ff00_80f1, 1'b0);
        load_step(32'h8000_0010, SZ_W, 1'b1, 64'h0000_0000_ff00_80f1, 1'b0);
        load_step(32'h8000_0014, SZ_W, 1'b0, 64'hffff_ffff_8081_7f02, 1'b0);
        load_step(32'h8000_0014, SZ_W, 1'b1, 64'h0000_0000_8081_7f02, 1'b0);
        load_step(32'h8000_0010, SZ_D, 1'b1, 64'h8081_7f02_ff00_80f1, 1'b0);
        // narrow stores with junk in the unused wdata bits
        store_step(32'h8000_0018, SZ_D, 64'h1111_2222_3333_4444, 1'b0);
        store_step(32'h8000_001b, SZ_B, 64'hdead_beef_0000_00aa, 1'b0);
        load_step(32'h8000_0018, SZ_D, 1'b0, 64'h1111_2222_aa33_4444, 1'b0);
        store_step(32'h8000_001c, SZ_H, 64'hffff_ffff_ffff_bcde, 1'b0);
        load_step(32'h8000_0018, SZ_D, 1'b0, 64'h1111_bcde_aa33_4444, 1'b0);
        // both halves of a line, then refetches that hit
        store_step(32'h8000_0100, SZ_D, 64'h0000_0013_0010_0093, 1'b0);
        store_step(32'h8000_0108, SZ_D, 64'hfe5f_f06f_0041_0113, 1'b0);
        fetch_step(32'h8000_0100, 32'h0010_0093, 1'b0);
        fetch_step(32'h8000_0104, 32'h0000_0013, 1'b0);
        fetch_step(32'h8000_0100, 32'h0010_0093, 1'b0);
        fetch_step(32'h8000_010c, 32'hfe5f_f06f, 1'b0);
        fetch_step(32'h8000_010c, 32'hfe5f_f06f, 1'b0);
        // error cases
        load_step(32'h8000_0001, SZ_H, 1'b0, 64'h0, 1'b1);
        load_step(32'h8000_0002, SZ_W, 1'b1, 64'h0, 1'b1);
        load_step(32'h8000_0004, SZ_D, 1'b0, 64'h0, 1'b1);
        store_step(32'h8000_000c, SZ_D, 64'h5555_6666_7777_8888, 1'b1);
        load_step(32'h8000_0008, SZ_D, 1'b0, 64'hfedc_ba98_7654_3210, 1'b0);
        load_step(32'h8000_1000, SZ_D, 1'b0, 64'h0, 1'b1);
        load_step(32'h7fff_fff8, SZ_W, 1'b0, 64'h0, 1'b1);
        // word 0x8000_1000 would alias index 0 without the range check
        store_step(32'h8000_1000, SZ_D, 64'h9999_aaaa_bbbb_cccc, 1'b1);
        load_step(32'h8000_0000, SZ_D, 1'b0, 64'h0123_4567_89ab_cdef, 1'b0);
        fetch_step(32'h8000_0102, 32'h0, 1'b1);
        fetch_step(32'h8000_2000, 32'h0, 1'b1);
        // a failed refill leaves no valid line behind
        fetch_step(32'h8000_2000, 32'h0, 1'b1);
        fetch_step(32'h8000_0100, 32'h0010_0093, 1'b0);
        // contention on the shared memory
        store_step(32'h8000_0200, SZ_D, 64'h0bad_c0de_8765_4321, 1'b0);
        store_step(32'h8000_0208, SZ_D, 64'h0000_0517_0000_0297, 1'b0);
        store_step(32'h8000_0210, SZ_D, 64'h0000_8067_fff0_0513, 1'b0);
        paired_step(32'h8000_0200, SZ_W, 1'b0, 64'hffff_ffff_8765_4321,
                    32'h8000_0208, 32'h0000_0297);
        paired_step(32'h8000_0206, SZ_H, 1'b1, 64'h0000_0000_0000_0bad,
                    32'h8000_0214, 32'h0000_8067);
    endtask

    // **************************************************************************
    // transactions and checks
    // **************************************************************************
    function automatic void compare_value(input string name, input logic [63:0] got,
                                          input logic [63:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            step_fails++;
        end
    endfunction

    // starts and ends on a falling edge
    task automatic data_txn(input step_t s, input int hold);
        core_mem_pkg::lsu_rsp_t rsp;
        lsu_valid_i = 1'b1;
        lsu_req_i   = '{addr: s.addr, we: s.we, size: s.size, unsigned_ld: s.uns,
                        wdata: s.wdata};
        while (!lsu_ready_o) @(negedge clk);
        @(negedge clk);
        lsu_valid_i = 1'b0;
        // busy after the accept edge
        compare_value("lsu_ready_o", 64'(lsu_ready_o), 64'h0);
        while (!lsu_rsp_valid_o) @(negedge clk);
        rsp = lsu_rsp_o;
        repeat (hold) @(negedge clk);
        lsu_rsp_ready_i = 1'b1;
        @(negedge clk);
        lsu_rsp_ready_i = 1'b0;
        compare_value("lsu_rsp_o.err", 64'(rsp.err), 64'(s.exp_err));
        // the old word returned by a good store is not compared
        if (!s.we || s.exp_err) begin
            compare_value("lsu_rsp_o.rdata", rsp.rdata, s.exp_data);
        end
    endtask

    task automatic fetch_txn(input step_t s, input int hold);
        core_mem_pkg::fetch_rsp_t rsp;
        fetch_valid_i = 1'b1;
        fetch_pc_i    = s.pc;
        while (!fetch_ready_o) @(negedge clk);
        @(negedge clk);
        fetch_valid_i = 1'b0;
        compare_value("fetch_ready_o", 64'(fetch_ready_o), 64'h0);
        while (!fetch_rsp_valid_o) @(negedge clk);
        rsp = fetch_rsp_o;
        repeat (hold) @(negedge clk);
        fetch_rsp_ready_i = 1'b1;
        @(negedge clk);
        fetch_rsp_ready_i = 1'b0;
        compare_value("fetch_rsp_o.err", 64'(rsp.err), 64'(s.exp_err));
        // misaligned pc carries no instruction
        if (s.pc[1:0] == 2'b00) begin
            compare_value("fetch_rsp_o.inst", 64'(rsp.inst), 64'(s.exp_inst));
        end
    endtask

    initial begin
        rst_n_i           = 1'b0;
        fetch_valid_i     = 1'b0;
        fetch_pc_i        = '0;
        fetch_rsp_ready_i = 1'b0;
        lsu_valid_i       = 1'b0;
        lsu_req_i         = '0;
        lsu_rsp_ready_i   = 1'b0;
        fill_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        // idle handshake levels right after reset
        step_fails = 0;
        compare_value("fetch_ready_o", 64'(fetch_ready_o), 64'h1);
        compare_value("lsu_ready_o", 64'(lsu_ready_o), 64'h1);
        compare_value("fetch_rsp_valid_o", 64'(fetch_rsp_valid_o), 64'h0);
        compare_value("lsu_rsp_valid_o", 64'(lsu_rsp_valid_o), 64'h0);
        $display("reset levels: %s", step_fails == 0 ? "ok" : "FAIL");
        if (step_fails != 0) begin
            fails++;
        end
        foreach (steps[i]) begin
            step_fails = 0;
            // ready stays low 1 to 4 cycles after each response
            hold_d = 1 + ($random(seed) & 3);
            hold_f = 1 + ($random(seed) & 3);
            case (steps[i].port)
                P_DATA: data_txn(steps[i], hold_d);
                P_FETCH: fetch_txn(steps[i], hold_f);
                default: begin
                    fork
                        data_txn(steps[i], hold_d);
                        fetch_txn(steps[i], hold_f);
                    join
                end
            endcase
            $display("step %0d %s addr %h pc %h: %s", i,
                     steps[i].port == P_DATA ? "data" :
                     steps[i].port == P_FETCH ? "fetch" : "both",
                     steps[i].addr, steps[i].pc, step_fails == 0 ? "ok" : "FAIL");
            if (step_fails != 0) begin
                fails++;
            end
        end
        $display("%0d tests run, %0d passed, %0d failed",
                 steps.size() + 1, steps.size() + 1 - fails, fails);
        if (fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        repeat (RESET_CYCLES + STEP_CYCLES * steps.size()) @(posedge clk);
        $display("timeout: the DUT stopped answering before all steps finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/core_mem_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_clkgen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_o
);

    // free running, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- hdl/core_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_top #(
    parameter int MEM_WORDS    = core_mem_pkg::MEM_WORDS_DEF,
    parameter int ICACHE_LINES = core_mem_pkg::ICACHE_LINES_DEF
) (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             fetch_valid_i,
    input  logic [core_mem_pkg::ADDR_W-1:0]  fetch_pc_i,
    input  logic                             fetch_rsp_ready_i,
    input  logic                             lsu_valid_i,
    input  core_mem_pkg::lsu_req_t           lsu_req_i,
    input  logic                             lsu_rsp_ready_i,
    output logic                             fetch_ready_o,
    output logic                             fetch_rsp_valid_o,
    output core_mem_pkg::fetch_rsp_t         fetch_rsp_o,
    output logic                             lsu_ready_o,
    output logic                             lsu_rsp_valid_o,
    output core_mem_pkg::lsu_rsp_t           lsu_rsp_o
);

    // **************************************************************************
    // requester side of the arbiter
    // **************************************************************************
    logic                     ic_req_valid;
    logic                     ic_req_ready;
    core_mem_pkg::bus_req_t   ic_req;
    logic                     ic_rsp_valid;
    logic                     ic_rsp_ready;
    core_mem_pkg::bus_rsp_t   ic_rsp;

    logic                     ls_req_valid;
    logic                     ls_req_ready;
    core_mem_pkg::bus_req_t   ls_req;
    logic                     ls_rsp_valid;
    logic                     ls_rsp_ready;
    core_mem_pkg::bus_rsp_t   ls_rsp;

    // arbiter to memory
    logic                     m_req_valid;
    logic                     m_req_ready;
    core_mem_pkg::bus_req_t   m_req;
    logic                     m_rsp_valid;
    logic                     m_rsp_ready;
    core_mem_pkg::bus_rsp_t   m_rsp;

    core_mem_icache #(
        .ICACHE_LINES (ICACHE_LINES)
    ) u_icache (
        .bus_req_ready_i (ic_req_ready),
        .bus_rsp_valid_i (ic_rsp_valid),
        .bus_rsp_i       (ic_rsp),
        .bus_req_valid_o (ic_req_valid),
        .bus_req_o       (ic_req),
        .bus_rsp_ready_o (ic_rsp_ready),
        .*
    );

    core_mem_lsu u_lsu (
        .bus_req_ready_i (ls_req_ready),
        .bus_rsp_valid_i (ls_rsp_valid),
        .bus_rsp_i       (ls_rsp),
        .bus_req_valid_o (ls_req_valid),
        .bus_req_o       (ls_req),
        .bus_rsp_ready_o (ls_rsp_ready),
        .*
    );

    // data accesses take priority over refills
    core_mem_arbiter u_arbiter (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .d_req_valid_i (ls_req_valid),
        .d_req_i       (ls_req),
        .d_rsp_ready_i (ls_rsp_ready),
        .f_req_valid_i (ic_req_valid),
        .f_req_i       (ic_req),
        .f_rsp_ready_i (ic_rsp_ready),
        .m_req_ready_i (m_req_ready),
        .m_rsp_valid_i (m_rsp_valid),
        .m_rsp_i       (m_rsp),
        .d_req_ready_o (ls_req_ready),
        .d_rsp_valid_o (ls_rsp_valid),
        .d_rsp_o       (ls_rsp),
        .f_req_ready_o (ic_req_ready),
        .f_rsp_valid_o (ic_rsp_valid),
        .f_rsp_o       (ic_rsp),
        .m_req_valid_o (m_req_valid),
        .m_req_o       (m_req),
        .m_rsp_ready_o (m_rsp_ready)
    );

    core_mem_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (m_req_valid),
        .req_i       (m_req),
        .rsp_ready_i (m_rsp_ready),
        .req_ready_o (m_req_ready),
        .rsp_valid_o (m_rsp_valid),
        .rsp_o       (m_rsp)
    );

endmodule

`default_nettype wire

//--- hdl/core_mem_sram.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_sram #(
    parameter int MEM_WORDS = core_mem_pkg::MEM_WORDS_DEF
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     req_valid_i,
    input  core_mem_pkg::bus_req_t   req_i,
    input  logic                     rsp_ready_i,
    output logic                     req_ready_o,
    output logic                     rsp_valid_o,
    output core_mem_pkg::bus_rsp_t   rsp_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [core_mem_pkg::DATA_W-1:0] mem [MEM_WORDS];
    logic [core_mem_pkg::ADDR_W-1:0] offset;
    logic [IDX_W-1:0]                idx;
    logic                            in_range;
    logic                            accept;

    // addresses below the base wrap to a large offset
    assign offset   = req_i.addr - core_mem_pkg::MEM_BASE;
    assign in_range = offset < 8 * MEM_WORDS;
    assign idx      = offset[IDX_W+2:3];

    assign req_ready_o = !rsp_valid_o;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else if (accept) begin
            rsp_valid_o <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    // read old word, then apply strobed bytes
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_o.err   <= !in_range;
            rsp_o.rdata <= in_range ? mem[idx] : '0;
            if (in_range && req_i.we) begin
                for (int b = 0; b < core_mem_pkg::STRB_W; b++) begin
                    if (req_i.strb[b]) begin
                        mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    a_rsp_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_valid_o && !rsp_ready_i |=> $stable(rsp_o));

endmodule

`default_nettype wire

//--- hdl/core_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_arbiter (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     d_req_valid_i,
    input  core_mem_pkg::bus_req_t   d_req_i,
    input  logic                     d_rsp_ready_i,
    input  logic                     f_req_valid_i,
    input  core_mem_pkg::bus_req_t   f_req_i,
    input  logic                     f_rsp_ready_i,
    input  logic                     m_req_ready_i,
    input  logic                     m_rsp_valid_i,
    input  core_mem_pkg::bus_rsp_t   m_rsp_i,
    output logic                     d_req_ready_o,
    output logic                     d_rsp_valid_o,
    output core_mem_pkg::bus_rsp_t   d_rsp_o,
    output logic                     f_req_ready_o,
    output logic                     f_rsp_valid_o,
    output core_mem_pkg::bus_rsp_t   f_rsp_o,
    output logic                     m_req_valid_o,
    output core_mem_pkg::bus_req_t   m_req_o,
    output logic                     m_rsp_ready_o
);

    logic busy_q;
    // high when the data side owns the bus
    logic owner_q;
    logic grant_d;

    // data wins while idle, locked owner while busy
    assign grant_d = busy_q ? owner_q : d_req_valid_i;

    assign m_req_valid_o = !busy_q && (d_req_valid_i || f_req_valid_i);
    assign m_req_o       = grant_d ? d_req_i : f_req_i;
    assign d_req_ready_o = !busy_q && m_req_ready_i;
    assign f_req_ready_o = !busy_q && !d_req_valid_i && m_req_ready_i;

    // response goes back to the owner only
    assign d_rsp_valid_o = busy_q && owner_q && m_rsp_valid_i;
    assign f_rsp_valid_o = busy_q && !owner_q && m_rsp_valid_i;
    assign d_rsp_o       = m_rsp_i;
    assign f_rsp_o       = m_rsp_i;
    assign m_rsp_ready_o = busy_q && (owner_q ? d_rsp_ready_i : f_rsp_ready_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
        end else if (m_req_valid_o && m_req_ready_i) begin
            busy_q  <= 1'b1;
            owner_q <= grant_d;
        end else if (m_rsp_valid_i && m_rsp_ready_o) begin
            busy_q <= 1'b0;
        end
    end

    a_no_stray_rsp : assert property (@(posedge clk) disable iff (!rst_n_i)
        m_rsp_valid_i |-> busy_q);

endmodule

`default_nettype wire

//--- hdl/core_mem_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_lsu (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       lsu_valid_i,
    input  core_mem_pkg::lsu_req_t     lsu_req_i,
    input  logic                       lsu_rsp_ready_i,
    input  logic                       bus_req_ready_i,
    input  logic                       bus_rsp_valid_i,
    input  core_mem_pkg::bus_rsp_t     bus_rsp_i,
    output logic                       lsu_ready_o,
    output logic                       lsu_rsp_valid_o,
    output core_mem_pkg::lsu_rsp_t     lsu_rsp_o,
    output logic                       bus_req_valid_o,
    output core_mem_pkg::bus_req_t     bus_req_o,
    output logic                       bus_rsp_ready_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_RESP
    } state_e;

    state_e                             state_q;
    core_mem_pkg::bus_req_t             req_q;
    core_mem_pkg::lsu_rsp_t             rsp_q;
    core_mem_pkg::ls_size_e             size_q;
    logic                               unsigned_q;
    logic [2:0]                         off_q;
    logic                               misaligned;
    logic                               sx;
    logic [core_mem_pkg::STRB_W-1:0]    strb_base;
    logic [core_mem_pkg::DATA_W-1:0]    shifted;
    logic [core_mem_pkg::DATA_W-1:0]    load_data;

    // alignment check and unshifted byte mask
    always_comb begin
        misaligned = 1'b0;
        strb_base  = '1;
        case (lsu_req_i.size)
            core_mem_pkg::LS_BYTE: begin
                strb_base = 8'h01;
            end
            core_mem_pkg::LS_HALF: begin
                misaligned = lsu_req_i.addr[0];
                strb_base  = 8'h03;
            end
            core_mem_pkg::LS_WORD: begin
                misaligned = |lsu_req_i.addr[1:0];
                strb_base  = 8'h0f;
            end
            default: begin
                misaligned = |lsu_req_i.addr[2:0];
            end
        endcase
    end

    // double loads ignore unsigned_ld
    always_comb begin
        shifted = bus_rsp_i.rdata >> (8 * off_q);
        sx      = !unsigned_q;
        case (size_q)
            core_mem_pkg::LS_BYTE: load_data = {{56{sx & shifted[7]}}, shifted[7:0]};
            core_mem_pkg::LS_HALF: load_data = {{48{sx & shifted[15]}}, shifted[15:0]};
            core_mem_pkg::LS_WORD: load_data = {{32{sx & shifted[31]}}, shifted[31:0]};
            default:               load_data = shifted;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (lsu_valid_i) begin
                        // misaligned goes straight to the error response
                        state_q <= misaligned ? S_RESP : S_REQ;
                    end
                end
                S_REQ: begin
                    if (bus_req_ready_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (bus_rsp_valid_i) begin
                        state_q <= S_RESP;
                    end
                end
                default: begin
                    if (lsu_rsp_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && lsu_valid_i) begin
            req_q.addr  <= {lsu_req_i.addr[core_mem_pkg::ADDR_W-1:3], 3'b000};
            req_q.we    <= lsu_req_i.we;
            req_q.wdata <= lsu_req_i.wdata << (8 * lsu_req_i.addr[2:0]);
            req_q.strb  <= strb_base << lsu_req_i.addr[2:0];
            size_q      <= lsu_req_i.size;
            unsigned_q  <= lsu_req_i.unsigned_ld;
            off_q       <= lsu_req_i.addr[2:0];
            rsp_q.rdata <= '0;
            rsp_q.err   <= misaligned;
        end else if (state_q == S_WAIT && bus_rsp_valid_i) begin
            rsp_q.rdata <= bus_rsp_i.err ? '0 : load_data;
            rsp_q.err   <= bus_rsp_i.err;
        end
    end

    assign lsu_ready_o     = (state_q == S_IDLE);
    assign lsu_rsp_valid_o = (state_q == S_RESP);
    assign lsu_rsp_o       = rsp_q;
    assign bus_req_valid_o = (state_q == S_REQ);
    assign bus_req_o       = req_q;
    assign bus_rsp_ready_o = (state_q == S_WAIT);

    // bus responses only reach the unit while it waits for one
    a_rsp_when_waiting : assert property (@(posedge clk) disable iff (!rst_n_i)
        bus_rsp_valid_i |-> bus_rsp_ready_o);

endmodule

`default_nettype wire

//--- hdl/core_mem_icache.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_icache #(
    parameter int ICACHE_LINES = core_mem_pkg::ICACHE_LINES_DEF
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              fetch_valid_i,
    input  logic [core_mem_pkg::ADDR_W-1:0]   fetch_pc_i,
    input  logic                              fetch_rsp_ready_i,
    input  logic                              bus_req_ready_i,
    input  logic                              bus_rsp_valid_i,
    input  core_mem_pkg::bus_rsp_t            bus_rsp_i,
    output logic                              fetch_ready_o,
    output logic                              fetch_rsp_valid_o,
    output core_mem_pkg::fetch_rsp_t          fetch_rsp_o,
    output logic                              bus_req_valid_o,
    output core_mem_pkg::bus_req_t            bus_req_o,
    output logic                              bus_rsp_ready_o
);

    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = core_mem_pkg::ADDR_W - 3 - IDX_W;
    localparam int IW    = core_mem_pkg::INST_W;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS_REQ,
        S_MISS_WAIT,
        S_RESP
    } state_e;

    state_e                            state_q;
    logic [core_mem_pkg::ADDR_W-1:0]   pc_q;
    logic [ICACHE_LINES-1:0]           valid_q;
    logic [TAG_W-1:0]                  tag_q  [ICACHE_LINES];
    logic [core_mem_pkg::DATA_W-1:0]   data_q [ICACHE_LINES];
    core_mem_pkg::fetch_rsp_t          rsp_q;
    core_mem_pkg::fetch_rsp_t          lookup_rsp;
    logic [IDX_W-1:0]                  idx;
    logic [TAG_W-1:0]                  tag;
    logic                              misaligned;
    logic                              hit;

    // index and tag of the latched pc
    assign idx        = pc_q[3 +: IDX_W];
    assign tag        = pc_q[core_mem_pkg::ADDR_W-1 -: TAG_W];
    assign misaligned = |pc_q[1:0];
    assign hit        = valid_q[idx] && (tag_q[idx] == tag);

    // pc bit 2 picks the half of the line
    assign lookup_rsp = '{inst: pc_q[2] ? data_q[idx][IW +: IW] : data_q[idx][0 +: IW],
                          err:  misaligned};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (fetch_valid_i) begin
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (!misaligned && !hit) begin
                        state_q <= S_MISS_REQ;
                    end else if (fetch_rsp_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                S_MISS_REQ: begin
                    if (bus_req_ready_i) begin
                        state_q <= S_MISS_WAIT;
                    end
                end
                S_MISS_WAIT: begin
                    if (bus_rsp_valid_i) begin
                        state_q <= S_RESP;
                        // a failed refill leaves the line invalid
                        if (!bus_rsp_i.err) begin
                            valid_q[idx] <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (fetch_rsp_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // pc capture and line refill
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && fetch_valid_i) begin
            pc_q <= fetch_pc_i;
        end
        if (state_q == S_MISS_WAIT && bus_rsp_valid_i) begin
            rsp_q.inst <= pc_q[2] ? bus_rsp_i.rdata[IW +: IW] : bus_rsp_i.rdata[0 +: IW];
            rsp_q.err  <= bus_rsp_i.err;
            if (!bus_rsp_i.err) begin
                tag_q[idx]  <= tag;
                data_q[idx] <= bus_rsp_i.rdata;
            end
        end
    end

    assign fetch_ready_o     = (state_q == S_IDLE);
    assign fetch_rsp_valid_o = (state_q == S_LOOKUP && (misaligned || hit)) || (state_q == S_RESP);
    assign fetch_rsp_o       = (state_q == S_RESP) ? rsp_q : lookup_rsp;

    // refill reads the whole aligned word
    assign bus_req_valid_o = (state_q == S_MISS_REQ);
    assign bus_req_o       = '{addr: {pc_q[core_mem_pkg::ADDR_W-1:3], 3'b000},
                               we: 1'b0, wdata: '0, strb: '1};
    assign bus_rsp_ready_o = (state_q == S_MISS_WAIT);

    // refill data only arrives while the cache waits for it
    a_rsp_when_waiting : assert property (@(posedge clk) disable iff (!rst_n_i)
        bus_rsp_valid_i |-> bus_rsp_ready_o);

endmodule

`default_nettype wire

//--- hdl/core_mem_pkg.sv
`default_nettype none

package core_mem_pkg;

    // **************************************************************************
    // bus geometry
    // **************************************************************************
    parameter int ADDR_W = 32;
    parameter int DATA_W = 64;
    parameter int STRB_W = DATA_W / 8;
    parameter int INST_W = 32;

    // memory map and default sizes
    parameter logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;
    parameter int MEM_WORDS_DEF = 512;
    // one bus word per line
    parameter int ICACHE_LINES_DEF = 16;

    // **************************************************************************
    // request and response payloads
    // **************************************************************************
    typedef enum logic [1:0] {
        LS_BYTE   = 2'd0,
        LS_HALF   = 2'd1,
        LS_WORD   = 2'd2,
        LS_DOUBLE = 2'd3
    } ls_size_e;

    // shared bus, addr is word aligned, strb marks the written bytes
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } bus_rsp_t;

    // data port, wdata right-aligned
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        ls_size_e          size;
        logic              unsigned_ld;
        logic [DATA_W-1:0] wdata;
    } lsu_req_t;

    // rdata already extended to full width
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } lsu_rsp_t;

    typedef struct packed {
        logic [INST_W-1:0] inst;
        logic              err;
    } fetch_rsp_t;

endpackage

`default_nettype wire
